// File: hw/l2_axi_pkg.sv
/* l2 memory port shared types */

package l2_axi_pkg;

    // burst and response encodings
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [2:0] AXI_SIZE_WORD  = 3'd2;   // 4 bytes per beat
    localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

    // fixed transaction ids, one per direction
    localparam logic [3:0] RD_ID = 4'd0;
    localparam logic [3:0] WR_ID = 4'd1;

    // read address channel, 45 bits
    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;       // beats minus one
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_ar_t;

    // write address channel, same layout as ar
    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
    } axi_r_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_t;

endpackage

// File: hw/l2_axi_read_channel.sv
/* axi read channel engine */
`timescale 1ns/100ps

module l2_axi_read_channel
    import l2_axi_pkg::*;
(
    input  logic    clk,
    input  logic    rstn,

    // from line unit
    input  logic    rd_start,
    input  axi_ar_t rd_cmd,

    // axi ar
    output axi_ar_t ar,
    output logic    arvalid,
    input  logic    arready,

    // axi r
    input  axi_r_t  r,
    input  logic    rvalid,
    output logic    rready,

    // beats back to line unit
    output axi_r_t  rd_beat,
    output logic    rd_beat_valid
);

    rd_state_t state;
    axi_ar_t   cmd_q;   // held stable while arvalid is up

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= RD_IDLE;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (rd_start) begin
                        state <= RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    if (arready) begin
                        state <= RD_DATA;   // address accepted
                    end
                end
                RD_DATA: begin
                    if (rvalid && r.last) begin
                        state <= RD_IDLE;
                    end
                end
                default: begin
                    state <= RD_IDLE;
                end
            endcase
        end
    end

    // command latched only when a new burst starts
    always_ff @(posedge clk) begin
        if (rd_start && state == RD_IDLE) begin
            cmd_q <= rd_cmd;
        end
    end

    assign ar      = cmd_q;
    assign arvalid = (state == RD_ADDR);
    assign rready  = (state == RD_DATA);

    // r beat passed straight up, qualified by the handshake
    assign rd_beat       = r;
    assign rd_beat_valid = rvalid && rready;

endmodule

// File: hw/l2_axi_write_channel.sv
/* axi write channel engine */
`timescale 1ns/100ps

module l2_axi_write_channel
    import l2_axi_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,

    // from line unit
    input  logic       wr_start,
    input  axi_aw_t    wr_cmd,
    input  axi_w_t     wr_beat,
    output logic       wr_beat_take,

    // axi aw
    output axi_aw_t    aw,
    output logic       awvalid,
    input  logic       awready,

    // axi w
    output axi_w_t     w,
    output logic       wvalid,
    input  logic       wready,

    // axi b
    input  logic [1:0] bresp,
    input  logic       bvalid,
    output logic       bready,

    // response back to line unit
    output logic [1:0] wr_resp,
    output logic       wr_resp_valid
);

    wr_state_t state;
    axi_aw_t   cmd_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= WR_IDLE;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (wr_start) begin
                        state <= WR_ADDR;
                    end
                end
                WR_ADDR: begin
                    if (awready) begin
                        state <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    // leave only once the final beat is accepted
                    if (wr_beat_take && wr_beat.last) begin
                        state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (bvalid) begin
                        state <= WR_IDLE;
                    end
                end
                default: begin
                    state <= WR_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_start && state == WR_IDLE) begin
            cmd_q <= wr_cmd;
        end
    end

    assign aw      = cmd_q;
    assign awvalid = (state == WR_ADDR);

    // current beat comes from the line serializer
    assign w            = wr_beat;
    assign wvalid       = (state == WR_DATA);
    assign wr_beat_take = wvalid && wready;   // advance serializer

    assign bready        = (state == WR_RESP);
    assign wr_resp       = bresp;
    assign wr_resp_valid = bvalid && bready;

endmodule

// File: hw/l2_line_xfer.sv
/* refill assembler and writeback serializer */
`timescale 1ns/100ps

module l2_line_xfer
    import l2_axi_pkg::*;
#(
    parameter int offset_width = 2
) (
    input  logic                           clk,
    input  logic                           rstn,

    // refill side of the l2
    input  logic                           refill_req,
    input  logic [31:0]                    refill_addr,
    output logic                           refill_busy,
    output logic                           refill_done,
    output logic [(32<<offset_width)-1:0]  refill_line,
    output logic                           refill_err,

    // writeback side of the l2
    input  logic                           wb_req,
    input  logic [31:0]                    wb_addr,
    input  logic [(32<<offset_width)-1:0]  wb_line,
    output logic                           wb_busy,
    output logic                           wb_done,
    output logic                           wb_err,

    // read engine
    output logic                           rd_start,
    output axi_ar_t                        rd_cmd,
    input  axi_r_t                         rd_beat,
    input  logic                           rd_beat_valid,

    // write engine
    output logic                           wr_start,
    output axi_aw_t                        wr_cmd,
    output axi_w_t                         wr_beat,
    input  logic                           wr_beat_take,
    input  logic [1:0]                     wr_resp,
    input  logic                           wr_resp_valid
);

    localparam int          line_w    = 32 << offset_width;
    localparam logic [7:0]  burst_len = 8'((1 << offset_width) - 1);

    logic [offset_width-1:0] rd_cnt;    // word slot of the next r beat
    logic [offset_width-1:0] wr_cnt;    // words already sent
    logic [line_w-1:0]       wb_shift;

    // strobes ignored while the matching side is busy
    assign rd_start = refill_req && !refill_busy;
    assign wr_start = wb_req && !wb_busy;

    assign rd_cmd = '{addr: refill_addr, len: burst_len, size: AXI_SIZE_WORD,
                      burst: AXI_BURST_INCR};
    assign wr_cmd = '{addr: wb_addr, len: burst_len, size: AXI_SIZE_WORD,
                      burst: AXI_BURST_INCR};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            refill_busy <= 1'b0;
            refill_done <= 1'b0;
            refill_err  <= 1'b0;
            rd_cnt      <= '0;
        end else begin
            refill_done <= rd_beat_valid && rd_beat.last;
            if (rd_start) begin
                refill_busy <= 1'b1;
                refill_err  <= 1'b0;
                rd_cnt      <= '0;
            end else if (rd_beat_valid) begin
                rd_cnt <= rd_cnt + 1'b1;
                if (rd_beat.resp != AXI_RESP_OKAY) begin
                    refill_err <= 1'b1;     // sticky for the whole burst
                end
                if (rd_beat.last) begin
                    refill_busy <= 1'b0;    // drops together with done
                end
            end
        end
    end

    // word 0 sits at the low end of the line
    always_ff @(posedge clk) begin
        if (rd_beat_valid) begin
            refill_line[rd_cnt*32 +: 32] <= rd_beat.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb_busy <= 1'b0;
            wb_done <= 1'b0;
            wb_err  <= 1'b0;
            wr_cnt  <= '0;
        end else begin
            wb_done <= wr_resp_valid;
            if (wr_start) begin
                wb_busy <= 1'b1;
                wr_cnt  <= '0;
            end else if (wr_beat_take) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            if (wr_resp_valid) begin
                wb_busy <= 1'b0;
                wb_err  <= (wr_resp != AXI_RESP_OKAY);
            end
        end
    end

    // victim line captured once, then shifted down a word per accepted beat
    always_ff @(posedge clk) begin
        if (wr_start) begin
            wb_shift <= wb_line;
        end else if (wr_beat_take) begin
            wb_shift <= {32'd0, wb_shift[line_w-1:32]};
        end
    end

    assign wr_beat = '{data: wb_shift[31:0], strb: 4'hf,
                       last: (wr_cnt == {offset_width{1'b1}})};

endmodule

// File: hw/l2_mem_port.sv
/* l2 cache axi memory port */
`timescale 1ns/100ps

module l2_mem_port
    import l2_axi_pkg::*;
#(
    parameter int offset_width = 2
) (
    input  logic                           clk,
    input  logic                           rstn,

    // l2 refill
    input  logic                           refill_req,
    input  logic [31:0]                    refill_addr,
    output logic                           refill_busy,
    output logic                           refill_done,
    output logic [(32<<offset_width)-1:0]  refill_line,
    output logic                           refill_err,

    // l2 writeback
    input  logic                           wb_req,
    input  logic [31:0]                    wb_addr,
    input  logic [(32<<offset_width)-1:0]  wb_line,
    output logic                           wb_busy,
    output logic                           wb_done,
    output logic                           wb_err,

    // axi ar
    output logic [31:0]                    araddr,
    output logic [7:0]                     arlen,
    output logic [2:0]                     arsize,
    output logic [1:0]                     arburst,
    output logic [3:0]                     arid,
    output logic                           arvalid,
    input  logic                           arready,

    // axi r
    input  logic [31:0]                    rdata,
    input  logic [1:0]                     rresp,
    input  logic                           rlast,
    input  logic                           rvalid,
    output logic                           rready,

    // axi aw
    output logic [31:0]                    awaddr,
    output logic [7:0]                     awlen,
    output logic [2:0]                     awsize,
    output logic [1:0]                     awburst,
    output logic [3:0]                     awid,
    output logic                           awvalid,
    input  logic                           awready,

    // axi w
    output logic [31:0]                    wdata,
    output logic [3:0]                     wstrb,
    output logic                           wlast,
    output logic                           wvalid,
    input  logic                           wready,

    // axi b
    input  logic [1:0]                     bresp,
    input  logic                           bvalid,
    output logic                           bready
);

    logic    rd_start;
    axi_ar_t rd_cmd;
    axi_r_t  rd_beat;
    logic    rd_beat_valid;

    logic       wr_start;
    axi_aw_t    wr_cmd;
    axi_w_t     wr_beat;
    logic       wr_beat_take;
    logic [1:0] wr_resp;
    logic       wr_resp_valid;

    axi_ar_t ar;
    axi_r_t  r;
    axi_aw_t aw;
    axi_w_t  w;

    // pin packing
    assign {araddr, arlen, arsize, arburst} = ar;
    assign {awaddr, awlen, awsize, awburst} = aw;
    assign {wdata, wstrb, wlast}            = w;
    assign r = '{data: rdata, resp: rresp, last: rlast};

    assign arid = RD_ID;
    assign awid = WR_ID;

    l2_line_xfer #(
        .offset_width (offset_width)
    ) line_xfer_i (
        .clk           (clk),
        .rstn          (rstn),
        .refill_req    (refill_req),
        .refill_addr   (refill_addr),
        .refill_busy   (refill_busy),
        .refill_done   (refill_done),
        .refill_line   (refill_line),
        .refill_err    (refill_err),
        .wb_req        (wb_req),
        .wb_addr       (wb_addr),
        .wb_line       (wb_line),
        .wb_busy       (wb_busy),
        .wb_done       (wb_done),
        .wb_err        (wb_err),
        .rd_start      (rd_start),
        .rd_cmd        (rd_cmd),
        .rd_beat       (rd_beat),
        .rd_beat_valid (rd_beat_valid),
        .wr_start      (wr_start),
        .wr_cmd        (wr_cmd),
        .wr_beat       (wr_beat),
        .wr_beat_take  (wr_beat_take),
        .wr_resp       (wr_resp),
        .wr_resp_valid (wr_resp_valid)
    );

    l2_axi_read_channel read_ch_i (
        .clk           (clk),
        .rstn          (rstn),
        .rd_start      (rd_start),
        .rd_cmd        (rd_cmd),
        .ar            (ar),
        .arvalid       (arvalid),
        .arready       (arready),
        .r             (r),
        .rvalid        (rvalid),
        .rready        (rready),
        .rd_beat       (rd_beat),
        .rd_beat_valid (rd_beat_valid)
    );

    l2_axi_write_channel write_ch_i (
        .clk           (clk),
        .rstn          (rstn),
        .wr_start      (wr_start),
        .wr_cmd        (wr_cmd),
        .wr_beat       (wr_beat),
        .wr_beat_take  (wr_beat_take),
        .aw            (aw),
        .awvalid       (awvalid),
        .awready       (awready),
        .w             (w),
        .wvalid        (wvalid),
        .wready        (wready),
        .bresp         (bresp),
        .bvalid        (bvalid),
        .bready        (bready),
        .wr_resp       (wr_resp),
        .wr_resp_valid (wr_resp_valid)
    );

endmodule

// File: verification/axi_mem_model.sv
/* axi slave memory model */
`timescale 1ns/100ps

module axi_mem_model (
    input  logic        clk,
    input  logic        rstn,
    input  logic [4:0]  go,         // per channel permission, 1 lets it move
    input  logic [31:0] araddr,
    input  logic [7:0]  arlen,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rlast,
    output logic        rvalid,
    input  logic        rready,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wlast,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready
);

    logic [31:0] mem [256];
    logic [31:0] rd_addr;
    logic [31:0] wr_addr;
    int          rd_left;   // beats still owed on the read burst
    bit          rd_busy;
    bit          wr_busy;
    bit          b_pending;
    bit          b_err;

    // slverr from 0x300 upwards
    function automatic logic [1:0] resp_for(input logic [31:0] addr);
        return (addr >= 32'h0000_0300) ? 2'b10 : 2'b00;
    endfunction

    task automatic clear_outputs();
        arready   = 1'b0;
        rvalid    = 1'b0;
        rdata     = '0;
        rresp     = 2'b00;
        rlast     = 1'b0;
        awready   = 1'b0;
        wready    = 1'b0;
        bvalid    = 1'b0;
        bresp     = 2'b00;
        rd_busy   = 1'b0;
        wr_busy   = 1'b0;
        b_pending = 1'b0;
        b_err     = 1'b0;
        rd_left   = 0;
    endtask

    // everything is decided on the falling edge and transfers on the next rising edge
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = (i * 4) ^ 32'h5a5a_0000;
        end
        clear_outputs();
        forever begin
            @(negedge clk);
            if (!rstn) begin
                clear_outputs();
            end else begin
                rvalid = rd_busy && go[1];
                rdata  = mem[rd_addr[9:2]];
                rresp  = resp_for(rd_addr);
                rlast  = (rd_left == 1);
                if (rvalid && rready) begin
                    rd_addr = rd_addr + 4;
                    rd_left = rd_left - 1;
                    rd_busy = (rd_left != 0);
                end
                arready = !rd_busy && go[0];
                if (arvalid && arready) begin
                    rd_addr = araddr;
                    rd_left = arlen + 1;
                    rd_busy = 1'b1;
                end

                bvalid = b_pending && go[4];
                bresp  = b_err ? 2'b10 : 2'b00;
                if (bvalid && bready) begin
                    b_pending = 1'b0;
                end
                wready = wr_busy && go[3];
                if (wvalid && wready) begin
                    mem[wr_addr[9:2]] = wdata;
                    b_err   = b_err || (resp_for(wr_addr) != 2'b00);
                    wr_addr = wr_addr + 4;
                    if (wlast) begin
                        wr_busy   = 1'b0;
                        b_pending = 1'b1;
                    end
                end
                awready = !wr_busy && !b_pending && go[2];
                if (awvalid && awready) begin
                    wr_addr = awaddr;
                    wr_busy = 1'b1;
                    b_err   = 1'b0;
                end
            end
        end
    end

endmodule

// File: verification/l2_mem_port_checker.sv
/* l2 memory port checker */
`timescale 1ns/100ps

module l2_mem_port_checker #(
    parameter int offset_width = 2
) (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           refill_req,
    input  logic [31:0]                    refill_addr,
    input  logic                           refill_busy,
    input  logic                           refill_done,
    input  logic [(32<<offset_width)-1:0]  refill_line,
    input  logic                           refill_err,
    input  logic                           wb_req,
    input  logic [31:0]                    wb_addr,
    input  logic [(32<<offset_width)-1:0]  wb_line,
    input  logic                           wb_busy,
    input  logic                           wb_done,
    input  logic                           wb_err,
    input  logic                           exp_refill_err,
    input  logic                           exp_wb_err,
    input  logic [31:0]                    araddr,
    input  logic [7:0]                     arlen,
    input  logic [2:0]                     arsize,
    input  logic [1:0]                     arburst,
    input  logic [3:0]                     arid,
    input  logic                           arvalid,
    input  logic                           arready,
    input  logic                           rvalid,
    input  logic                           rready,
    input  logic [31:0]                    awaddr,
    input  logic [7:0]                     awlen,
    input  logic [2:0]                     awsize,
    input  logic [1:0]                     awburst,
    input  logic [3:0]                     awid,
    input  logic                           awvalid,
    input  logic                           awready,
    input  logic [31:0]                    wdata,
    input  logic [3:0]                     wstrb,
    input  logic                           wlast,
    input  logic                           wvalid,
    input  logic                           wready,
    input  logic                           bvalid,
    input  logic                           bready,
    output int                             errors
);

    localparam int words  = 1 << offset_width;
    localparam int line_w = 32 * words;

    typedef logic [line_w-1:0] line_t;

    logic [31:0] image [256];   // what memory should hold
    line_t       exp_line;
    line_t       exp_wb_line;   // victim line of the running writeback
    logic [31:0] exp_araddr;
    logic [31:0] exp_awaddr;
    logic        exp_rerr;
    logic        exp_werr;
    bit          rd_pending;
    bit          wb_pending;
    bit          rstn_q;
    int          rd_beats;
    int          w_beats;

    task automatic compare_value(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report(input string what);
        $display("Error at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic check_cycle();
        int base;
        // busy is high from the cycle after the strobe until done
        compare_value("refill_busy", line_t'(refill_busy),
                      line_t'(rd_pending && !refill_done));
        compare_value("wb_busy", line_t'(wb_busy), line_t'(wb_pending && !wb_done));
        if (refill_done) begin
            if (!rd_pending) begin
                report("refill_done arrived with no refill outstanding");
            end else begin
                compare_value("refill_line", refill_line, exp_line);
                compare_value("refill_err", line_t'(refill_err), line_t'(exp_rerr));
                compare_value("r beat count", line_t'(rd_beats), line_t'(words));
            end
            rd_pending = 1'b0;
        end
        if (wb_done) begin
            if (!wb_pending) begin
                report("wb_done arrived with no writeback outstanding");
            end else begin
                compare_value("wb_err", line_t'(wb_err), line_t'(exp_werr));
                compare_value("w beat count", line_t'(w_beats), line_t'(words));
            end
            wb_pending = 1'b0;
        end
        // expected len, size, burst and id
        if (arvalid && arready) begin
            compare_value("araddr", line_t'(araddr), line_t'(exp_araddr));
            compare_value("ar len/size/burst/id", line_t'({arlen, arsize, arburst, arid}),
                          line_t'({8'(words - 1), 3'd2, 2'b01, 4'd0}));
        end
        if (awvalid && awready) begin
            compare_value("awaddr", line_t'(awaddr), line_t'(exp_awaddr));
            compare_value("aw len/size/burst/id", line_t'({awlen, awsize, awburst, awid}),
                          line_t'({8'(words - 1), 3'd2, 2'b01, 4'd1}));
        end
        if (rvalid && rready) begin
            rd_beats++;
        end
        if (wvalid && wready) begin
            w_beats++;
            compare_value("wdata", line_t'(wdata),
                          line_t'(exp_wb_line[(w_beats - 1)*32 +: 32]));
            compare_value("wlast", line_t'(wlast), line_t'(w_beats == words));
            compare_value("wstrb", line_t'(wstrb), line_t'(4'hf));
        end
        if (refill_req && !rd_pending) begin
            base = int'(refill_addr[9:2]);
            for (int i = 0; i < words; i++) begin
                exp_line[i*32 +: 32] = image[base + i];
            end
            exp_araddr = refill_addr;
            exp_rerr   = exp_refill_err;
            rd_pending = 1'b1;
            rd_beats   = 0;
        end
        if (wb_req && !wb_pending) begin
            base = int'(wb_addr[9:2]);
            for (int i = 0; i < words; i++) begin
                image[base + i] = wb_line[i*32 +: 32];
            end
            exp_awaddr  = wb_addr;
            exp_wb_line = wb_line;
            exp_werr    = exp_wb_err;
            wb_pending  = 1'b1;
            w_beats     = 0;
        end
    endtask

    initial begin
        errors     = 0;
        rd_pending = 1'b0;
        wb_pending = 1'b0;
        rstn_q     = 1'b0;
        rd_beats   = 0;
        w_beats    = 0;
        for (int i = 0; i < 256; i++) begin
            image[i] = (i * 4) ^ 32'h5a5a_0000;
        end
        forever begin
            @(negedge clk);
            #1;     // mid cycle so inputs and registered outputs have settled
            if (rstn && !rstn_q) begin
                compare_value("idle outputs after reset",
                              line_t'({arvalid, rready, awvalid, wvalid, bready, refill_busy,
                                       refill_done, wb_busy, wb_done}), '0);
            end
            rstn_q = rstn;
            if (rstn) begin
                check_cycle();
            end
        end
    end

endmodule

// File: verification/tb_l2_mem_port.sv
/* l2 memory port testbench */
`timescale 1ns/100ps

module tb_l2_mem_port;

    localparam int offset_width   = 2;
    localparam int line_w         = 32 << offset_width;
    localparam int timeout_cycles = 400;

    localparam logic [1:0] K_REFILL = 2'd0;
    localparam logic [1:0] K_WB     = 2'd1;
    localparam logic [1:0] K_BOTH   = 2'd2;   // refill and writeback in one cycle
    localparam logic [1:0] K_BUSY   = 2'd3;   // refill plus a second strobe while busy

    typedef struct packed {
        logic [1:0]        kind;
        logic [31:0]       addr;      // refill address
        logic [31:0]       wb_addr;   // writeback address, or the busy strobe address
        logic [line_w-1:0] line;
        logic              rerr;
        logic              werr;
    } row_t;

    row_t rows [9] = '{
        '{K_REFILL, 32'h0000_0000, 32'h0, 128'h0, 1'b0, 1'b0},
        '{K_WB, 32'h0, 32'h0000_0040, 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210,
          1'b0, 1'b0},
        '{K_REFILL, 32'h0000_0040, 32'h0, 128'h0, 1'b0, 1'b0},
        '{K_BOTH, 32'h0000_0080, 32'h0000_00c0, 128'hdead_beef_cafe_f00d_1357_9bdf_2468_ace0,
          1'b0, 1'b0},
        '{K_REFILL, 32'h0000_00c0, 32'h0, 128'h0, 1'b0, 1'b0},
        '{K_REFILL, 32'h0000_0300, 32'h0, 128'h0, 1'b1, 1'b0},   // error region
        '{K_WB, 32'h0, 32'h0000_0340, 128'ha5a5_a5a5_5a5a_5a5a_0f0f_0f0f_f0f0_f0f0,
          1'b0, 1'b1},
        '{K_BUSY, 32'h0000_0100, 32'h0000_0200, 128'h0, 1'b0, 1'b0},
        '{K_REFILL, 32'h0000_0200, 32'h0, 128'h0, 1'b0, 1'b0}
    };

    logic              clk;
    logic              rstn;
    logic              refill_req, refill_busy, refill_done, refill_err;
    logic [31:0]       refill_addr;
    logic [line_w-1:0] refill_line;
    logic              wb_req, wb_busy, wb_done, wb_err;
    logic [31:0]       wb_addr;
    logic [line_w-1:0] wb_line;
    logic [31:0]       araddr, awaddr, rdata, wdata;
    logic [7:0]        arlen, awlen;
    logic [2:0]        arsize, awsize;
    logic [1:0]        arburst, awburst, rresp, bresp;
    logic [3:0]        arid, awid, wstrb;
    logic              arvalid, arready, rlast, rvalid, rready;
    logic              awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic              exp_refill_err, exp_wb_err;
    logic [4:0]        go;
    logic [31:0]       lfsr;
    int                errors;
    int                timeouts = 0;

    l2_mem_port #(.offset_width(offset_width)) dut_i (.*);
    axi_mem_model mem_i (.*);
    l2_mem_port_checker #(.offset_width(offset_width)) chk_i (.*);

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // fresh stall bits each rising edge, read by the model on the falling edge
    initial begin
        lfsr = 32'h0b6b_7dbe;
        go   = '0;
        forever begin
            @(posedge clk);
            for (int i = 0; i < 5; i++) begin
                lfsr  = lfsr_step(lfsr);
                go[i] = lfsr[0];
            end
        end
    end

    task automatic wait_done(input bit want_rd, input bit want_wb);
        int n;
        bit rd_seen;
        bit wb_seen;
        n       = 0;
        rd_seen = !want_rd;
        wb_seen = !want_wb;
        while (!(rd_seen && wb_seen) && n < timeout_cycles) begin
            @(negedge clk);
            rd_seen = rd_seen || refill_done;
            wb_seen = wb_seen || wb_done;
            n++;
        end
        if (!rd_seen) begin
            $display("Timeout: refill_done never came within %0d cycles", n);
            timeouts++;
        end
        if (!wb_seen) begin
            $display("Timeout: wb_done never came within %0d cycles", n);
            timeouts++;
        end
    endtask

    task automatic apply_row(input row_t row);
        @(negedge clk);
        refill_addr    = row.addr;
        wb_addr        = row.wb_addr;
        wb_line        = row.line;
        exp_refill_err = row.rerr;
        exp_wb_err     = row.werr;
        refill_req     = (row.kind != K_WB);
        wb_req         = (row.kind == K_WB) || (row.kind == K_BOTH);
        @(negedge clk);
        refill_req = 1'b0;
        wb_req     = 1'b0;
        if (row.kind == K_BUSY) begin
            @(negedge clk);
            refill_addr = row.wb_addr;   // must be dropped, refill still running
            refill_req  = 1'b1;
            @(negedge clk);
            refill_req = 1'b0;
        end
        wait_done(row.kind != K_WB, (row.kind == K_WB) || (row.kind == K_BOTH));
    endtask

    initial begin
        rstn           = 1'b0;
        refill_req     = 1'b0;
        refill_addr    = '0;
        wb_req         = 1'b0;
        wb_addr        = '0;
        wb_line        = '0;
        exp_refill_err = 1'b0;
        exp_wb_err     = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        repeat (20) @(negedge clk);     // room for a stray done to show up
        $display("checker errors %0d, timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
hw/l2_axi_pkg.sv
hw/l2_axi_read_channel.sv
hw/l2_axi_write_channel.sv
hw/l2_line_xfer.sv
hw/l2_mem_port.sv
verification/axi_mem_model.sv
verification/l2_mem_port_checker.sv
verification/tb_l2_mem_port.sv

// File: run_sim.sh
#!/bin/sh
# build and run the l2 memory port testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module tb_l2_mem_port -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
